// ==== list.f ====
+incdir+verilog
verilog/dma_pkg.sv
verilog/dma_if.sv
verilog/dma_regs.sv
verilog/dma_engine.sv
verilog/dma_byte_chan.sv
verilog/dma_dev_merge.sv
verilog/dma_top.sv
test/dma_sva.sv
test/tb_dma.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' list.f) verilog/dma_cfg.svh

.PHONY: all run clean

all: obj_dir/Vtb_dma

obj_dir/Vtb_dma: list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module tb_dma -Mdir obj_dir -o Vtb_dma

run: obj_dir/Vtb_dma
	@out="$$(./obj_dir/Vtb_dma +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

// ==== test/tb_dma.sv ====
// --------------------------------------------------------------------------
// DMA testbench with a DRAM model for word addresses 0..4095 only
// byte channel models answer after a random delay and the first error ends the run
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module tb_dma;
	localparam int NCH         = `DMA_NUM_CH;
	localparam int DLY_MAX     = 4;
	localparam int TOTAL_WORDS = 8 + 6 + 5;
	localparam int WORD_CYC    = 3 * (DLY_MAX + 2); // up to three handshakes per word

	logic clk = 1'b0;
	logic rst_n, c2, rfsh_n;
	logic [7:0] dmaport_wr, zdata;
	logic dma_act, dma_wait;
	logic [`DMA_ADDR_W-1:0] dram_addr;
	logic [15:0] dram_rddata, dram_wrdata;
	logic dram_req, dram_rnw, dram_next;
	logic [NCH-1:0] ch_req, ch_rnw, ch_stb;
	logic [NCH-1:0][7:0] ch_wrdata, ch_rddata;

	logic [15:0] mem [0:4095];
	int dram_dly;
	int ch_dly [NCH];
	int rd_cnt [NCH];
	int stb_cnt [NCH];
	logic [7:0] wr_q [$]; // bytes sent to the device
	logic exp_wait;

	dma_top dut0 (.*);

	always #10 clk = ~clk;

	function automatic logic [15:0] fill(input logic [11:0] a);
		return {a[11:8] ^ 4'h9, a[3:0] ^ 4'h6, a[7:0]};
	endfunction

	function automatic logic [7:0] pat(input int k, input int n);
		return {k[1:0], n[5:0]} ^ 8'h3c;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp)
		else
		begin
			$display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			fail_run("value mismatch");
		end
	endtask

	task automatic reg_write(input int r, input logic [7:0] v, input logic with_c2);
		@(negedge clk);
		dmaport_wr = 8'(1 << r);
		zdata      = v;
		c2         = with_c2;
		@(negedge clk);
		dmaport_wr = '0;
		c2         = 1'b0;
	endtask

	task automatic set_addrs(input logic [20:0] src, input logic [20:0] dst, input logic [7:0] n);
		reg_write(0, {src[6:0], 1'b0}, 1'b0);
		reg_write(1, src[14:7], 1'b0);
		reg_write(2, {2'b00, src[20:15]}, 1'b0);
		reg_write(3, {dst[6:0], 1'b0}, 1'b0);
		reg_write(4, dst[14:7], 1'b0);
		reg_write(5, {2'b00, dst[20:15]}, 1'b0);
		reg_write(6, n, 1'b0);
	endtask

	// refresh, launch, optional blocked writes, wait for the end
	task automatic run_burst(input logic [7:0] ctrl, input logic junk);
		exp_wait = ctrl[6];
		for (int k = 0; k < NCH; k++)
		begin
			rd_cnt[k]  = 0;
			stb_cnt[k] = 0;
		end
		wr_q.delete();
		@(negedge clk);
		rfsh_n = 1'b0;
		@(negedge clk);
		rfsh_n = 1'b1;
		reg_write(7, ctrl, 1'b1);
		while (!dma_act)
			@(negedge clk);
		if (junk)
			for (int r = 0; r < 8; r++)
				reg_write(r, 8'hff, 1'b0);
		while (dma_act)
		begin
			check_val("dma_wait", 16'(dma_wait), 16'(exp_wait));
			@(negedge clk);
		end
	endtask

	// DRAM answers after a random number of cycles
	always @(negedge clk)
	begin
		if (dram_next)
			dram_next = 1'b0;
		else if (dram_req)
		begin
			if (dram_dly == 0)
			begin
				dram_next = 1'b1;
				if (dram_rnw)
					dram_rddata = mem[dram_addr[11:0]];
				else
					mem[dram_addr[11:0]] = dram_wrdata;
				dram_dly = $urandom_range(DLY_MAX, 0);
			end
			else
				dram_dly--;
		end
	end

	always @(negedge clk)
	begin
		for (int k = 0; k < NCH; k++)
		begin
			if (ch_stb[k])
				ch_stb[k] = 1'b0;
			else if (ch_req[k])
			begin
				if (ch_dly[k] == 0)
				begin
					ch_stb[k] = 1'b1;
					stb_cnt[k]++;
					if (ch_rnw[k])
					begin
						ch_rddata[k] = pat(k, rd_cnt[k]);
						rd_cnt[k]++;
					end
					else
						wr_q.push_back(ch_wrdata[k]);
					ch_dly[k] = $urandom_range(DLY_MAX, 0);
				end
				else
					ch_dly[k]--;
			end
		end
	end

	always @(negedge clk)
		if (dut0.u_sva.err_cnt != 0)
			fail_run("an assertion in dma_sva failed");

	initial
	begin
		#(TOTAL_WORDS * WORD_CYC * 20 + 400 * 20);
		fail_run("watchdog expired before the tests finished");
	end

	initial
	begin
		void'($urandom(32'h26c9d488));
		rst_n = 1'b0;
		c2 = 1'b0;
		rfsh_n = 1'b1;
		dmaport_wr = '0;
		zdata = '0;
		dram_next = 1'b0;
		dram_rddata = '0;
		dram_dly = 0;
		ch_stb = '0;
		ch_rddata = '0;
		for (int k = 0; k < NCH; k++)
			ch_dly[k] = 0;
		for (int i = 0; i < 4096; i++)
			mem[i] = fill(12'(i));
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		repeat (5) @(negedge clk); // idle checked by a_idle

		// RAM to RAM with zwait on and writes while active
		set_addrs(21'h00100, 21'h00400, 8'd7);
		run_burst(8'h41, 1'b1);
		for (int i = 0; i < 8; i++)
			check_val($sformatf("mem[%0h]", 12'h400 + i), mem[12'h400 + i],
				fill(12'(12'h100 + i)));

		// channel 1 into RAM
		set_addrs(21'h00000, 21'h00600, 8'd5);
		run_burst(8'h83, 1'b0);
		for (int i = 0; i < 6; i++)
			check_val($sformatf("mem[%0h]", 12'h600 + i), mem[12'h600 + i],
				{pat(1, 2 * i + 1), pat(1, 2 * i)});
		check_val("ch_stb[1] count", 16'(stb_cnt[1]), 16'd12);
		check_val("ch_stb[0] count", 16'(stb_cnt[0]), 16'd0);
		check_val("ch_stb[2] count", 16'(stb_cnt[2]), 16'd0);

		// RAM to channel 2 with lo byte first
		set_addrs(21'h00200, 21'h00000, 8'd4);
		run_burst(8'h04, 1'b0);
		check_val("ch_wrdata byte count", 16'(wr_q.size()), 16'd10);
		for (int i = 0; i < 5; i++)
		begin
			check_val($sformatf("ch_wrdata[2] lo %0d", i), 16'(wr_q[2 * i]),
				16'(fill(12'(12'h200 + i)) & 16'h00ff));
			check_val($sformatf("ch_wrdata[2] hi %0d", i), 16'(wr_q[2 * i + 1]),
				16'(fill(12'(12'h200 + i)) >> 8));
		end

		// no refresh since the last burst so no launch
		reg_write(7, 8'h41, 1'b1);
		repeat (4) @(negedge clk);
		assert (!dma_act)
		else
			fail_run("launch without a refresh cycle raised dma_act");

		if (dut0.u_sva.err_cnt == 0)
		begin
			$display("TB PASSED");
			$finish;
		end
		else
			fail_run("assertion failures were counted");
	end

endmodule

`default_nettype wire

// ==== test/dma_sva.sv ====
// --------------------------------------------------------------------------
// protocol assertions for dma_top attached by bind
// err_cnt counts the failed assertions
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_sva
(
	input logic                   clk,
	input logic                   rst_n,
	input logic                   dma_act,
	input logic                   dma_wait,
	input logic                   launch,
	input logic                   dram_req,
	input logic                   dram_next,
	input logic [`DMA_ADDR_W-1:0] dram_addr,
	input logic [`DMA_NUM_CH-1:0] ch_req,
	input logic [2:0]             dev
);
	int err_cnt = 0;

	logic [`DMA_NUM_CH-1:0] sel_mask; // channel that dev points at

	always_comb
	begin
		sel_mask = '0;
		for (int i = 0; i < `DMA_NUM_CH; i++)
			if (dev == 3'(i + 2))
				sel_mask[i] = 1'b1;
	end

	a_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!dma_act |-> (!dram_req && ch_req == '0 && !dma_wait))
	else
	begin
		err_cnt++;
		$error("requests or wait while idle");
	end

	a_chan: assert property (@(posedge clk) disable iff (!rst_n)
		(ch_req & ~sel_mask) == '0)
	else
	begin
		err_cnt++;
		$error("ch_req on a channel that is not selected");
	end

	a_launch: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(dma_act) |-> $past(launch))
	else
	begin
		err_cnt++;
		$error("dma_act rose without a launch");
	end

	// held request keeps its address until acknowledged
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(dram_req && !dram_next) |=> (dram_req && $stable(dram_addr)))
	else
	begin
		err_cnt++;
		$error("dram_req dropped or address moved before dram_next");
	end

endmodule

bind dma_top dma_sva u_sva
(
	.clk       (clk),
	.rst_n     (rst_n),
	.dma_act   (dma_act),
	.dma_wait  (dma_wait),
	.launch    (launch),
	.dram_req  (dram_req),
	.dram_next (dram_next),
	.dram_addr (dram_addr),
	.ch_req    (ch_req),
	.dev       (dev)
);

`default_nettype wire

// ==== verilog/dma_top.sv ====
// --------------------------------------------------------------------------
// DMA top: Z80 registers, engine, DMA_NUM_CH byte channels, return merge
// per channel signals are arrays indexed by channel number
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_top
(
	input  logic                        clk,
	input  logic                        c2,
	input  logic                        rst_n,
	input  logic [7:0]                  dmaport_wr,
	input  logic [7:0]                  zdata,
	input  logic                        rfsh_n,
	output logic                        dma_act,
	output logic                        dma_wait,
	output logic [`DMA_ADDR_W-1:0]      dram_addr,
	input  logic [15:0]                 dram_rddata,
	output logic [15:0]                 dram_wrdata,
	output logic                        dram_req,
	output logic                        dram_rnw,
	input  logic                        dram_next,
	output logic [`DMA_NUM_CH-1:0]      ch_req,
	output logic [`DMA_NUM_CH-1:0]      ch_rnw,
	output logic [`DMA_NUM_CH-1:0][7:0] ch_wrdata,
	input  logic [`DMA_NUM_CH-1:0][7:0] ch_rddata,
	input  logic [`DMA_NUM_CH-1:0]      ch_stb
);
	import dma_pkg::*;

	logic [`DMA_ADDR_W-1:0] s_addr;
	logic [`DMA_ADDR_W-1:0] d_addr;
	logic [`DMA_LEN_W-1:0]  len;
	dev_t                   dev;
	logic                   wnr;
	logic                   zwait;
	logic                   launch;

	logic [`DMA_NUM_CH-1:0]      word_stb;
	dma_word_u [`DMA_NUM_CH-1:0] rdword;
	logic                        dev_stb;
	dma_word_u                   dev_word;

	dma_dev_if dev_bus ();

	dma_regs u_regs
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.c2         (c2),
		.rfsh_n     (rfsh_n),
		.dmaport_wr (dmaport_wr),
		.zdata      (zdata),
		.act        (dma_act),
		.s_addr     (s_addr),
		.d_addr     (d_addr),
		.len        (len),
		.dev        (dev),
		.wnr        (wnr),
		.zwait      (zwait),
		.launch     (launch)
	);

	dma_engine u_engine
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.launch      (launch),
		.s_addr      (s_addr),
		.d_addr      (d_addr),
		.len         (len),
		.dev         (dev),
		.wnr         (wnr),
		.zwait       (zwait),
		.act         (dma_act),
		.dma_wait    (dma_wait),
		.dram_addr   (dram_addr),
		.dram_rddata (dram_rddata),
		.dram_wrdata (dram_wrdata),
		.dram_req    (dram_req),
		.dram_rnw    (dram_rnw),
		.dram_next   (dram_next),
		.bus         (dev_bus),
		.dev_stb     (dev_stb),
		.dev_word    (dev_word)
	);

	for (genvar i = 0; i < `DMA_NUM_CH; i++)
	begin : g_chan
		dma_byte_chan #(.IDX(i)) u_chan
		(
			.clk       (clk),
			.rst_n     (rst_n),
			.bus       (dev_bus),
			.ch_req    (ch_req[i]),
			.ch_rnw    (ch_rnw[i]),
			.ch_wrdata (ch_wrdata[i]),
			.ch_rddata (ch_rddata[i]),
			.ch_stb    (ch_stb[i]),
			.word_stb  (word_stb[i]),
			.rdword    (rdword[i])
		);
	end

	dma_dev_merge u_merge
	(
		.word_stb (word_stb),
		.rdword   (rdword),
		.dev_stb  (dev_stb),
		.dev_word (dev_word)
	);

endmodule

`default_nettype wire

// ==== verilog/dma_dev_merge.sv ====
// --------------------------------------------------------------------------
// folds the channel returns into one; only the selected channel is non-zero
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_dev_merge
(
	input  logic [`DMA_NUM_CH-1:0]               word_stb,
	input  dma_pkg::dma_word_u [`DMA_NUM_CH-1:0] rdword,
	output logic                                 dev_stb,
	output dma_pkg::dma_word_u                   dev_word
);

	logic [15:0] acc;

	assign dev_stb = |word_stb;

	always_comb
	begin
		acc = '0;
		for (int i = 0; i < `DMA_NUM_CH; i++)
			acc = acc | rdword[i].word;
		dev_word.word = acc;
	end

endmodule

`default_nettype wire

// ==== verilog/dma_byte_chan.sv ====
// --------------------------------------------------------------------------
// one byte wide peripheral, a word is two stb cycles, low byte first
// stb is only taken while this channel holds ch_req
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_byte_chan
#(
	parameter int IDX = 0
)
(
	input  logic               clk,
	input  logic               rst_n,
	dma_dev_if.chan            bus,
	output logic               ch_req,
	output logic               ch_rnw,
	output logic [7:0]         ch_wrdata,
	input  logic [7:0]         ch_rddata,
	input  logic               ch_stb,
	output logic               word_stb,
	output dma_pkg::dma_word_u rdword
);
	import dma_pkg::*;

	localparam dev_t MY_DEV = dev_t'(int'(DEV_CH0) + IDX);

	logic       sel;
	logic       stb_ok;
	logic       bsel; // 0 lo, 1 hi
	logic [7:0] lo_q;
	dma_word_u  asm_word;

	assign sel    = bus.act && (bus.dev == MY_DEV);
	assign ch_req = sel & bus.req;
	assign ch_rnw = bus.rnw;
	assign stb_ok = ch_req & ch_stb;

	assign ch_wrdata = bsel ? bus.wrword.b.hi : bus.wrword.b.lo;

	// byte select restarts with every burst
	always_ff @(posedge clk)
	begin
		if (!rst_n || !bus.act)
			bsel <= 1'b0;
		else if (stb_ok)
			bsel <= ~bsel;
	end

	always_ff @(posedge clk)
	begin
		if (stb_ok && bus.rnw && !bsel)
			lo_q <= ch_rddata;
	end

	// second byte closes the word
	assign word_stb = stb_ok & bsel;

	always_comb
	begin
		asm_word.b.lo = lo_q;
		asm_word.b.hi = ch_rddata; // hi straight from the bus
	end

	// zero unless returning, so the merge can OR
	assign rdword = (word_stb && bus.rnw) ? asm_word : '0;

endmodule

`default_nettype wire

// ==== verilog/dma_engine.sv ====
// --------------------------------------------------------------------------
// burst engine: read phase then write phase per word, len+1 words
// a device code with no channel behind it stalls the burst until reset
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_engine
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   launch,
	input  logic [`DMA_ADDR_W-1:0] s_addr,
	input  logic [`DMA_ADDR_W-1:0] d_addr,
	input  logic [`DMA_LEN_W-1:0]  len,
	input  dma_pkg::dev_t          dev,
	input  logic                   wnr,
	input  logic                   zwait,
	output logic                   act,
	output logic                   dma_wait,
	output logic [`DMA_ADDR_W-1:0] dram_addr,
	input  logic [15:0]            dram_rddata,
	output logic [15:0]            dram_wrdata,
	output logic                   dram_req,
	output logic                   dram_rnw,
	input  logic                   dram_next,
	dma_dev_if.eng                 bus,
	input  logic                   dev_stb,
	input  dma_pkg::dma_word_u     dev_word
);
	import dma_pkg::*;

	logic [`DMA_LEN_W:0]   ctr;   // top bit set = idle
	logic                  phase; // 0 read, 1 write
	logic [`DMA_ADDR_W-1:0] sa;
	logic [`DMA_ADDR_W-1:0] da;
	dma_word_u             data;

	logic dev_ram;
	logic src_mem;
	logic dst_mem;
	logic mem_phase;
	logic phase_end;

	assign act      = ~ctr[`DMA_LEN_W];
	assign dma_wait = act & zwait;

	assign dev_ram = (dev == DEV_RAM);
	assign src_mem = dev_ram | ~wnr;
	assign dst_mem = dev_ram | wnr;

	// which side this phase talks to
	assign mem_phase = phase ? dst_mem : src_mem;
	assign phase_end = act & (mem_phase ? dram_next : dev_stb);

	assign dram_addr   = phase ? da : sa;
	assign dram_wrdata = data.word;
	assign dram_req    = act & mem_phase;
	assign dram_rnw    = ~phase;

	assign bus.act    = act;
	assign bus.req    = act & ~mem_phase;
	assign bus.rnw    = ~phase;
	assign bus.dev    = act ? dev : DEV_NONE;
	assign bus.wrword = data;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ctr   <= {1'b1, {`DMA_LEN_W{1'b0}}};
			phase <= 1'b0;
		end
		else if (launch)
		begin
			ctr   <= {1'b0, len};
			phase <= 1'b0;
		end
		else if (phase_end)
		begin
			phase <= ~phase;
			if (phase)
				ctr <= ctr - 1'b1; // wraps into idle after last word
		end
	end

	// running addresses step on each DRAM acknowledge
	always_ff @(posedge clk)
	begin
		if (launch)
		begin
			sa <= s_addr;
			da <= d_addr;
		end
		else if (act && mem_phase && dram_next)
		begin
			if (phase)
				da <= da + 1'b1;
			else
				sa <= sa + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (phase_end && !phase)
			data <= mem_phase ? dma_word_u'(dram_rddata) : dev_word;
	end

endmodule

`default_nettype wire

// ==== verilog/dma_regs.sv ====
// --------------------------------------------------------------------------
// Z80 side registers, one write strobe per register, shared data byte
// writes are dropped while a burst runs; launch needs a refresh seen first
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_regs
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  c2,
	input  logic                  rfsh_n,
	input  logic [7:0]            dmaport_wr,
	input  logic [7:0]            zdata,
	input  logic                  act,
	output logic [`DMA_ADDR_W-1:0] s_addr,
	output logic [`DMA_ADDR_W-1:0] d_addr,
	output logic [`DMA_LEN_W-1:0]  len,
	output dma_pkg::dev_t         dev,
	output logic                  wnr,
	output logic                  zwait,
	output logic                  launch
);
	import dma_pkg::*;

	logic [7:0] wr;    // strobes after blocking
	logic       armed;

	assign wr = dmaport_wr & {8{~act}};

	// control write on c2 starts the burst
	assign launch = wr[7] & c2 & armed;

	always_ff @(posedge clk)
	begin
		// low byte carries address bits 6:0 in zdata 7:1
		if (wr[0])
			s_addr[6:0] <= zdata[7:1];
		if (wr[1])
			s_addr[14:7] <= zdata;
		if (wr[2])
			s_addr[`DMA_ADDR_W-1:15] <= zdata[`DMA_ADDR_W-16:0];

		if (wr[3])
			d_addr[6:0] <= zdata[7:1];
		if (wr[4])
			d_addr[14:7] <= zdata;
		if (wr[5])
			d_addr[`DMA_ADDR_W-1:15] <= zdata[`DMA_ADDR_W-16:0];

		if (wr[6])
			len <= zdata[`DMA_LEN_W-1:0];

		if (wr[7])
		begin
			wnr   <= zdata[7]; // 1 = device to RAM
			zwait <= zdata[6]; // hold Z80 during burst
			dev   <= dev_t'(zdata[2:0]);
		end
	end

	// one refresh cycle since the last burst arms the next launch
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			armed <= 1'b0;
		else if (!rfsh_n)
			armed <= 1'b1;
		else if (act)
			armed <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verilog/dma_if.sv ====
// --------------------------------------------------------------------------
// engine to byte channel broadcast, one driver and any number of readers
// dev reads as DEV_NONE while no burst runs
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface dma_dev_if;
	import dma_pkg::*;

	logic      act;    // burst running
	logic      req;    // device side requested in this phase
	logic      rnw;    // read phase
	dev_t      dev;    // selected device code
	dma_word_u wrword; // word to send in the write phase

	modport eng
	(
		output act,
		output req,
		output rnw,
		output dev,
		output wrword
	);

	modport chan
	(
		input act,
		input req,
		input rnw,
		input dev,
		input wrword
	);

endinterface

`default_nettype wire

// ==== verilog/dma_pkg.sv ====
// --------------------------------------------------------------------------
// device codes and word view shared by the DMA blocks
// codes above the last channel select nothing and stall a burst until reset
// --------------------------------------------------------------------------
`default_nettype none

package dma_pkg;

	// device select field of the control register
	typedef logic [2:0] dev_t;

	localparam dev_t DEV_NONE = 3'd0;
	localparam dev_t DEV_RAM  = 3'd1;
	localparam dev_t DEV_CH0  = 3'd2; // channel k is DEV_CH0 + k

	typedef struct packed
	{
		logic [7:0] hi;
		logic [7:0] lo;
	} byte_pair_t;

	// DRAM sees the whole word, byte channels see two bytes
	typedef union packed
	{
		logic [15:0] word;
		byte_pair_t  b;
	} dma_word_u;

endpackage

`default_nettype wire

// ==== verilog/dma_cfg.svh ====
// --------------------------------------------------------------------------
// sizes of the burst DMA
// DMA_ADDR_W stays between 16 and 23 as the extension register holds bits 15 up
// --------------------------------------------------------------------------
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// DRAM word address width
`define DMA_ADDR_W 21

// burst length register width
`define DMA_LEN_W 8

// number of byte wide peripheral channels
`define DMA_NUM_CH 3

`endif
